//--- hw/spc2wbm_params.svh
`ifndef SPC2WBM_PARAMS_SVH
`define SPC2WBM_PARAMS_SVH

// Core side packet widths
`define SPC2WBM_PCX_WIDTH 124
`define SPC2WBM_CPX_WIDTH 145

// Wishbone data and address width
`define SPC2WBM_WB_WIDTH 64

// One select bit per data byte
`define SPC2WBM_SEL_WIDTH 8

// Target region, one-hot as driven on spc_req_i
`define SPC2WBM_REGION_WIDTH 5

// Physical address carried in a PCX packet
`define SPC2WBM_ADDR_WIDTH 40

// Zero gap between region and address on the bus
`define SPC2WBM_ADDR_PAD 19

// Boot ROM sits behind the I/O region
`define SPC2WBM_IO_REGION 5'b10000

// Payload of the wakeup packet
`define SPC2WBM_WAKEUP_DATA 64'h0000_0000_0001_0001

`endif

//--- hw/spc2wbm_pkg.sv
`include "spc2wbm_params.svh"

package spc2wbm_pkg;

  // PCX request types handled by the bridge
  typedef enum logic [4:0] {
    LOAD_RQ  = 5'b00000,
    STORE_RQ = 5'b00001,
    IMISS_RQ = 5'b10000
  } pcx_req_e;

  // Access size field, 16 bytes only for reads
  typedef enum logic [2:0] {
    SZ_1B  = 3'b000,
    SZ_2B  = 3'b001,
    SZ_4B  = 3'b010,
    SZ_8B  = 3'b011,
    SZ_16B = 3'b111
  } pcx_size_e;

  // CPX return types
  typedef enum logic [3:0] {
    LOAD_RET  = 4'b0000,
    IFILL_RET = 4'b0001,
    ST_ACK    = 4'b0100,
    INT_RET   = 4'b0111
  } cpx_ret_e;

  // Request packet from the core, top bit first
  typedef struct packed {
    logic                            valid;
    pcx_req_e                        rqtype;
    logic                            nc;
    logic [2:0]                      cpu_id;
    logic [1:0]                      thread;
    logic                            invalidate;
    logic [1:0]                      unused;
    logic [1:0]                      way;
    pcx_size_e                       size;
    logic [`SPC2WBM_ADDR_WIDTH-1:0]  addr;
    logic [`SPC2WBM_WB_WIDTH-1:0]    data;
  } pcx_packet_t;

  // Return packet to the core, top bit first
  typedef struct packed {
    logic                            valid;
    cpx_ret_e                        rtype;
    logic                            miss;
    logic [1:0]                      error;
    logic                            nc;
    logic [1:0]                      thread;
    logic                            way_valid;
    logic [1:0]                      way;
    logic                            boot_fetch;
    logic                            atomic;
    logic                            pfl;
    logic [2*`SPC2WBM_WB_WIDTH-1:0]  data;
  } cpx_packet_t;

endpackage

//--- hw/bridge_req_if.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

interface bridge_req_if;
  // Latched request fields
  logic [`SPC2WBM_REGION_WIDTH-1:0] region;
  logic                             atomic;
  spc2wbm_pkg::pcx_req_e            req_type;
  spc2wbm_pkg::pcx_size_e           size;
  logic [`SPC2WBM_ADDR_WIDTH-1:0]   addr;
  logic [`SPC2WBM_WB_WIDTH-1:0]     st_data;
  logic                             nc;
  logic [1:0]                       thread;
  // Decoded per-request values
  logic [`SPC2WBM_SEL_WIDTH-1:0]    sel;
  logic                             we;
  spc2wbm_pkg::cpx_ret_e            ret_type;
  logic                             boot;
  // Total beats, 1, 2 or 4
  logic [2:0]                       beats;

  modport source (output region, atomic, req_type, size, addr, st_data, nc, thread,
                  sel, we, ret_type, boot, beats);
  modport sink (input region, atomic, req_type, size, addr, st_data, nc, thread,
                sel, we, ret_type, boot, beats);
endinterface

//--- hw/bridge_fsm.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module bridge_fsm (
  input  logic                             clk,
  input  logic                             sys_reset_i,
  input  logic [`SPC2WBM_REGION_WIDTH-1:0] spc_req_i,
  input  logic                             wbm_ack_i,
  input  logic                             last_beat_i,
  output logic                             req_latch_o,
  output logic                             pkt_latch_o,
  output logic                             beat_start_o,
  output logic                             final_o,
  output logic                             spc_stall_o,
  output logic                             spc_grant_valid_o
);

  typedef enum logic [2:0] {
    ST_WAKEUP,
    ST_IDLE,
    ST_STALL,
    ST_GRANT,
    ST_ISSUE,
    ST_WAIT,
    ST_READY
  } state_e;

  state_e state;
  state_e state_nxt;

  always_ff @(posedge clk) begin
    if (sys_reset_i) begin
      state <= ST_WAKEUP;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      // Wakeup packet leaves while we sit here one cycle
      ST_WAKEUP: state_nxt = ST_IDLE;
      ST_IDLE: begin
        if (|spc_req_i) begin
          state_nxt = ST_STALL;
        end
      end
      // Packet is on spc_packetout_i now
      ST_STALL: state_nxt = ST_GRANT;
      ST_GRANT: state_nxt = ST_WAIT;
      ST_ISSUE: state_nxt = ST_WAIT;
      ST_WAIT: begin
        if (wbm_ack_i) begin
          state_nxt = last_beat_i ? ST_READY : ST_ISSUE;
        end
      end
      ST_READY: state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  // Region and atomic are sampled on the request edge itself
  assign req_latch_o       = (state == ST_IDLE) && (|spc_req_i);
  assign pkt_latch_o       = (state == ST_STALL);
  assign spc_stall_o       = (state == ST_STALL);
  assign spc_grant_valid_o = (state == ST_GRANT);
  // Beat 0 issues from grant, later beats from issue
  assign beat_start_o      = (state == ST_GRANT) || (state == ST_ISSUE);
  assign final_o           = (state == ST_READY);

endmodule

//--- hw/beat_counter.sv
`timescale 1ns/100ps

module beat_counter (
  input  logic              clk,
  input  logic              sys_reset_i,
  input  logic              pkt_latch_i,
  input  logic              wbm_ack_i,
  bridge_req_if.sink        req,
  output logic [1:0]        beat_idx_o,
  output logic              last_beat_o,
  output logic              mid_packet_o
);

  always_ff @(posedge clk) begin
    if (sys_reset_i) begin
      beat_idx_o   <= 2'd0;
      mid_packet_o <= 1'b0;
    end else begin
      // Fresh request restarts at beat 0
      if (pkt_latch_i) begin
        beat_idx_o <= 2'd0;
      end else if (wbm_ack_i) begin
        beat_idx_o <= beat_idx_o + 2'd1;
      end
      // First half of a 4-beat fill is complete
      mid_packet_o <= wbm_ack_i && (beat_idx_o == 2'd1) && (req.beats == 3'd4);
    end
  end

  assign last_beat_o = ({1'b0, beat_idx_o} == (req.beats - 3'd1));

endmodule

//--- hw/pcx_decoder.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module pcx_decoder (
  input  logic                             clk,
  input  logic [`SPC2WBM_REGION_WIDTH-1:0] spc_req_i,
  input  logic                             spc_atom_i,
  input  logic [`SPC2WBM_PCX_WIDTH-1:0]    spc_packetout_i,
  input  logic                             req_latch_i,
  input  logic                             pkt_latch_i,
  bridge_req_if.source                     req
);

  spc2wbm_pkg::pcx_packet_t         pkt_in;
  spc2wbm_pkg::pcx_packet_t         pkt_q;
  logic [`SPC2WBM_REGION_WIDTH-1:0] region_q;
  logic                             atomic_q;
  logic                             io_req;
  logic [`SPC2WBM_SEL_WIDTH-1:0]    sel_d;
  logic [`SPC2WBM_SEL_WIDTH-1:0]    sel_q;
  logic                             we_d;
  logic                             we_q;
  logic [2:0]                       beats_d;
  logic [2:0]                       beats_q;
  spc2wbm_pkg::cpx_ret_e            ret_d;
  spc2wbm_pkg::cpx_ret_e            ret_q;
  logic                             boot_q;

  // Byte lanes for a sub-doubleword access
  function automatic logic [`SPC2WBM_SEL_WIDTH-1:0] size_sel(
    input spc2wbm_pkg::pcx_size_e sz,
    input logic [2:0]             lo
  );
    case (sz)
      spc2wbm_pkg::SZ_1B:  return 8'h01 << lo;
      spc2wbm_pkg::SZ_2B:  return 8'h03 << {lo[2:1], 1'b0};
      spc2wbm_pkg::SZ_4B:  return 8'h0f << {lo[2], 2'b00};
      spc2wbm_pkg::SZ_8B,
      spc2wbm_pkg::SZ_16B: return 8'hff;
      default:             return 8'h00;
    endcase
  endfunction

  assign pkt_in = spc2wbm_pkg::pcx_packet_t'(spc_packetout_i);
  assign io_req = (region_q == `SPC2WBM_IO_REGION);

  always_comb begin
    // Unsupported types write one empty beat and get ST_ACK
    sel_d   = '0;
    we_d    = 1'b1;
    beats_d = 3'd1;
    ret_d   = spc2wbm_pkg::ST_ACK;
    case (pkt_in.rqtype)
      spc2wbm_pkg::LOAD_RQ: begin
        sel_d   = size_sel(pkt_in.size, pkt_in.addr[2:0]);
        we_d    = 1'b0;
        beats_d = (pkt_in.size == spc2wbm_pkg::SZ_16B) ? 3'd2 : 3'd1;
        ret_d   = spc2wbm_pkg::LOAD_RET;
      end
      spc2wbm_pkg::STORE_RQ: begin
        sel_d = size_sel(pkt_in.size, pkt_in.addr[2:0]);
      end
      spc2wbm_pkg::IMISS_RQ: begin
        // Boot ROM returns one 32-bit word per beat
        sel_d   = io_req ? size_sel(spc2wbm_pkg::SZ_4B, pkt_in.addr[2:0]) : 8'hff;
        we_d    = 1'b0;
        beats_d = io_req ? 3'd2 : 3'd4;
        ret_d   = spc2wbm_pkg::IFILL_RET;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_latch_i) begin
      region_q <= spc_req_i;
      atomic_q <= spc_atom_i;
    end
    if (pkt_latch_i) begin
      pkt_q   <= pkt_in;
      sel_q   <= sel_d;
      we_q    <= we_d;
      beats_q <= beats_d;
      ret_q   <= ret_d;
      boot_q  <= io_req;
    end
  end

  assign req.region   = region_q;
  assign req.atomic   = atomic_q;
  assign req.req_type = pkt_q.rqtype;
  assign req.size     = pkt_q.size;
  assign req.addr     = pkt_q.addr;
  assign req.st_data  = pkt_q.data;
  assign req.nc       = pkt_q.nc;
  assign req.thread   = pkt_q.thread;
  assign req.sel      = sel_q;
  assign req.we       = we_q;
  assign req.ret_type = ret_q;
  assign req.boot     = boot_q;
  assign req.beats    = beats_q;

endmodule

//--- hw/wb_master.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module wb_master (
  input  logic                          clk,
  input  logic                          sys_reset_i,
  input  logic                          beat_start_i,
  input  logic                          wbm_ack_i,
  input  logic [1:0]                    beat_idx_i,
  bridge_req_if.sink                    req,
  output logic                          wbm_cycle_o,
  output logic                          wbm_strobe_o,
  output logic                          wbm_we_o,
  output logic [`SPC2WBM_WB_WIDTH-1:0]  wbm_addr_o,
  output logic [`SPC2WBM_WB_WIDTH-1:0]  wbm_data_o,
  output logic [`SPC2WBM_SEL_WIDTH-1:0] wbm_sel_o
);

  localparam int AW = `SPC2WBM_ADDR_WIDTH;

  logic [AW-1:0] beat_addr;
  logic          first_beat;

  assign first_beat = (beat_idx_i == 2'd0);

  // Doubleword offset inside the line for each beat
  always_comb begin
    case (beat_idx_i)
      2'd0:    beat_addr = {req.addr[AW-1:3], 3'b000};
      2'd1:    beat_addr = {req.addr[AW-1:4], 4'b1000};
      2'd2:    beat_addr = {req.addr[AW-1:5], 5'b10000};
      default: beat_addr = {req.addr[AW-1:5], 5'b11000};
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_reset_i) begin
      wbm_cycle_o  <= 1'b0;
      wbm_strobe_o <= 1'b0;
      wbm_we_o     <= 1'b0;
      wbm_addr_o   <= '0;
      wbm_data_o   <= '0;
      wbm_sel_o    <= '0;
    end else if (beat_start_i) begin
      wbm_cycle_o  <= 1'b1;
      wbm_strobe_o <= 1'b1;
      // Only beat 0 can write, later beats are fill reads
      wbm_we_o     <= first_beat ? req.we : 1'b0;
      wbm_addr_o   <= {req.region, {`SPC2WBM_ADDR_PAD{1'b0}}, beat_addr};
      wbm_data_o   <= first_beat ? req.st_data : '0;
      wbm_sel_o    <= first_beat ? req.sel : '1;
    end else if (wbm_ack_i) begin
      // Atomic requests hold the bus between beats
      wbm_cycle_o  <= req.atomic;
      wbm_strobe_o <= 1'b0;
      wbm_we_o     <= 1'b0;
      wbm_addr_o   <= '0;
      wbm_data_o   <= '0;
      wbm_sel_o    <= '0;
    end
  end

endmodule

//--- hw/cpx_encoder.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module cpx_encoder (
  input  logic                             clk,
  input  logic                             sys_reset_i,
  input  logic                             wbm_ack_i,
  input  logic [`SPC2WBM_WB_WIDTH-1:0]     wbm_data_i,
  input  logic [1:0]                       beat_idx_i,
  input  logic                             mid_packet_i,
  input  logic                             final_i,
  input  logic                             grant_valid_i,
  bridge_req_if.sink                       req,
  output logic [`SPC2WBM_REGION_WIDTH-1:0] spc_grant_o,
  output logic                             spc_ready_o,
  output logic [`SPC2WBM_CPX_WIDTH-1:0]    spc_packetin_o
);

  localparam logic [`SPC2WBM_WB_WIDTH-1:0] ZERO_DW = '0;

  spc2wbm_pkg::cpx_packet_t pkt_q;
  logic                     wake_armed;
  logic                     wake_q;
  logic                     mid_q;
  logic                     send;

  always_ff @(posedge clk) begin
    if (sys_reset_i) begin
      wake_armed <= 1'b1;
      wake_q     <= 1'b0;
      mid_q      <= 1'b0;
    end else begin
      // One-shot wakeup right after reset
      wake_q     <= wake_armed;
      wake_armed <= 1'b0;
      // Delay so the first fill packet lines up with beat 2
      mid_q      <= mid_packet_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_reset_i) begin
      // Wakeup packet
      pkt_q       <= '0;
      pkt_q.valid <= 1'b1;
      pkt_q.rtype <= spc2wbm_pkg::INT_RET;
      pkt_q.data  <= {ZERO_DW, `SPC2WBM_WAKEUP_DATA};
    end else if (grant_valid_i) begin
      // Header for the new request, data filled in per beat
      pkt_q            <= '0;
      pkt_q.valid      <= 1'b1;
      pkt_q.rtype      <= req.ret_type;
      pkt_q.nc         <= req.nc;
      pkt_q.thread     <= req.thread;
      pkt_q.boot_fetch <= req.boot;
      pkt_q.atomic     <= (req.req_type == spc2wbm_pkg::IMISS_RQ) ? 1'b0 : req.atomic;
    end else if (wbm_ack_i) begin
      case (beat_idx_i)
        2'd0: pkt_q.data <= req.addr[3] ? {ZERO_DW, wbm_data_i} : {wbm_data_i, ZERO_DW};
        2'd1: pkt_q.data[`SPC2WBM_WB_WIDTH-1:0] <= wbm_data_i;
        2'd2: pkt_q.data <= {wbm_data_i, ZERO_DW};
        default: begin
          // Second fill packet is flagged by the atomic bit
          pkt_q.data[`SPC2WBM_WB_WIDTH-1:0] <= wbm_data_i;
          pkt_q.atomic <= 1'b1;
        end
      endcase
    end
  end

  assign send           = wake_q | mid_q | final_i;
  assign spc_ready_o    = send;
  assign spc_packetin_o = send ? pkt_q : '0;
  assign spc_grant_o    = grant_valid_i ? req.region : '0;

endmodule

//--- hw/spc2wbm_top.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module spc2wbm_top (
  input  logic                             clk,
  input  logic                             sys_reset_i,
  input  logic [`SPC2WBM_REGION_WIDTH-1:0] spc_req_i,
  input  logic                             spc_atom_i,
  input  logic [`SPC2WBM_PCX_WIDTH-1:0]    spc_packetout_i,
  input  logic                             wbm_ack_i,
  input  logic [`SPC2WBM_WB_WIDTH-1:0]     wbm_data_i,
  output logic [`SPC2WBM_REGION_WIDTH-1:0] spc_grant_o,
  output logic                             spc_ready_o,
  output logic [`SPC2WBM_CPX_WIDTH-1:0]    spc_packetin_o,
  output logic                             spc_stall_o,
  output logic                             spc_resume_o,
  output logic                             wbm_cycle_o,
  output logic                             wbm_strobe_o,
  output logic                             wbm_we_o,
  output logic [`SPC2WBM_WB_WIDTH-1:0]     wbm_addr_o,
  output logic [`SPC2WBM_WB_WIDTH-1:0]     wbm_data_o,
  output logic [`SPC2WBM_SEL_WIDTH-1:0]    wbm_sel_o
);

  // Sequencing strobes
  logic       req_latch;
  logic       pkt_latch;
  logic       beat_start;
  logic       grant_valid;
  // Beat tracking
  logic [1:0] beat_idx;
  logic       last_beat;
  logic       mid_packet;

  bridge_req_if req ();

  bridge_fsm u_fsm (
    .clk               (clk),
    .sys_reset_i       (sys_reset_i),
    .spc_req_i         (spc_req_i),
    .wbm_ack_i         (wbm_ack_i),
    .last_beat_i       (last_beat),
    .req_latch_o       (req_latch),
    .pkt_latch_o       (pkt_latch),
    .beat_start_o      (beat_start),
    .final_o           (spc_resume_o),
    .spc_stall_o       (spc_stall_o),
    .spc_grant_valid_o (grant_valid)
  );

  beat_counter u_beat_counter (
    .clk          (clk),
    .sys_reset_i  (sys_reset_i),
    .pkt_latch_i  (pkt_latch),
    .wbm_ack_i    (wbm_ack_i),
    .req          (req.sink),
    .beat_idx_o   (beat_idx),
    .last_beat_o  (last_beat),
    .mid_packet_o (mid_packet)
  );

  pcx_decoder u_pcx_decoder (
    .clk             (clk),
    .spc_req_i       (spc_req_i),
    .spc_atom_i      (spc_atom_i),
    .spc_packetout_i (spc_packetout_i),
    .req_latch_i     (req_latch),
    .pkt_latch_i     (pkt_latch),
    .req             (req.source)
  );

  wb_master u_wb_master (
    .clk          (clk),
    .sys_reset_i  (sys_reset_i),
    .beat_start_i (beat_start),
    .wbm_ack_i    (wbm_ack_i),
    .beat_idx_i   (beat_idx),
    .req          (req.sink),
    .wbm_cycle_o  (wbm_cycle_o),
    .wbm_strobe_o (wbm_strobe_o),
    .wbm_we_o     (wbm_we_o),
    .wbm_addr_o   (wbm_addr_o),
    .wbm_data_o   (wbm_data_o),
    .wbm_sel_o    (wbm_sel_o)
  );

  // Final return packet goes out with the resume pulse
  cpx_encoder u_cpx_encoder (
    .clk            (clk),
    .sys_reset_i    (sys_reset_i),
    .wbm_ack_i      (wbm_ack_i),
    .wbm_data_i     (wbm_data_i),
    .beat_idx_i     (beat_idx),
    .mid_packet_i   (mid_packet),
    .final_i        (spc_resume_o),
    .grant_valid_i  (grant_valid),
    .req            (req.sink),
    .spc_grant_o    (spc_grant_o),
    .spc_ready_o    (spc_ready_o),
    .spc_packetin_o (spc_packetin_o)
  );

endmodule

//--- tests/wb_slave_model.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module wb_slave_model (
  input  logic                         clk,
  input  logic                         sys_reset_i,
  input  logic                         strobe_i,
  input  logic [`SPC2WBM_WB_WIDTH-1:0] addr_i,
  output logic                         ack_o,
  output logic [`SPC2WBM_WB_WIDTH-1:0] data_o
);

  logic busy;
  int   wait_cnt;

  initial begin
    ack_o    = 1'b0;
    data_o   = '0;
    busy     = 1'b0;
    wait_cnt = 0;
  end

  // Outputs change on the falling edge, bridge samples on the rising edge
  always @(negedge clk) begin
    if (sys_reset_i) begin
      ack_o  = 1'b0;
      data_o = '0;
      busy   = 1'b0;
    end else if (ack_o) begin
      // Ack is a single-cycle pulse
      ack_o  = 1'b0;
      data_o = '0;
    end else if (strobe_i) begin
      // New beat picks its own latency
      if (!busy) begin
        busy     = 1'b1;
        wait_cnt = $urandom_range(5, 0);
      end
      if (wait_cnt == 0) begin
        ack_o  = 1'b1;
        // Read data is the inverted beat address
        data_o = ~addr_i;
        busy   = 1'b0;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

//--- tests/tb_spc2wbm.sv
`timescale 1ns/100ps
`include "spc2wbm_params.svh"

module tb_spc2wbm;

  localparam int ACK_LIMIT = 20;
  localparam int RANDOM_REQS = 40;
  // Request code the bridge does not support
  localparam logic [4:0] UNSUP_RQ = 5'b00100;

  logic                               clk = 1'b0;
  logic                               sys_reset;
  logic [`SPC2WBM_REGION_WIDTH-1:0]   spc_req;
  logic                               spc_atom;
  logic [`SPC2WBM_PCX_WIDTH-1:0]      spc_packet;
  logic                               wbm_ack;
  logic [`SPC2WBM_WB_WIDTH-1:0]       wbm_rdata;
  logic [`SPC2WBM_REGION_WIDTH-1:0]   spc_grant;
  logic                               spc_ready;
  logic [`SPC2WBM_CPX_WIDTH-1:0]      spc_packetin;
  logic                               spc_stall;
  logic                               spc_resume;
  logic                               wbm_cycle;
  logic                               wbm_strobe;
  logic                               wbm_we;
  logic [`SPC2WBM_WB_WIDTH-1:0]       wbm_addr;
  logic [`SPC2WBM_WB_WIDTH-1:0]       wbm_wdata;
  logic [`SPC2WBM_SEL_WIDTH-1:0]      wbm_sel;

  int          req_count;
  logic [2:0]  sizes [5];

  // 100 ns clock
  always #50 clk = ~clk;

  spc2wbm_top dut0 (
    .clk             (clk),
    .sys_reset_i     (sys_reset),
    .spc_req_i       (spc_req),
    .spc_atom_i      (spc_atom),
    .spc_packetout_i (spc_packet),
    .wbm_ack_i       (wbm_ack),
    .wbm_data_i      (wbm_rdata),
    .spc_grant_o     (spc_grant),
    .spc_ready_o     (spc_ready),
    .spc_packetin_o  (spc_packetin),
    .spc_stall_o     (spc_stall),
    .spc_resume_o    (spc_resume),
    .wbm_cycle_o     (wbm_cycle),
    .wbm_strobe_o    (wbm_strobe),
    .wbm_we_o        (wbm_we),
    .wbm_addr_o      (wbm_addr),
    .wbm_data_o      (wbm_wdata),
    .wbm_sel_o       (wbm_sel)
  );

  wb_slave_model slave0 (
    .clk         (clk),
    .sys_reset_i (sys_reset),
    .strobe_i    (wbm_strobe),
    .addr_i      (wbm_addr),
    .ack_o       (wbm_ack),
    .data_o      (wbm_rdata)
  );

  task automatic compare(input string name, input logic [159:0] expected,
                         input logic [159:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("Done: errors found");
    $fatal(1, "stopped on timeout");
  endtask

  // Return packet, fields top bit first
  function automatic logic [`SPC2WBM_CPX_WIDTH-1:0] build_cpx(
    input logic [3:0]   rtype,
    input logic         nc,
    input logic [1:0]   thread,
    input logic         boot,
    input logic         atomic,
    input logic [127:0] data
  );
    return {1'b1, rtype, 1'b0, 2'b00, nc, thread, 1'b0, 2'b00, boot, atomic, 1'b0, data};
  endfunction

  // Doubleword address of each beat in a line
  function automatic logic [39:0] beat_address(input logic [39:0] a, input int b);
    case (b)
      0:       return a & ~40'h7;
      1:       return (a & ~40'hf) | 40'h8;
      2:       return (a & ~40'h1f) | 40'h10;
      default: return (a & ~40'h1f) | 40'h18;
    endcase
  endfunction

  // Byte lanes of beat 0 from size and address
  function automatic logic [7:0] beat0_select(input logic [4:0] rq, input logic [2:0] sz,
                                              input logic [2:0] lo, input logic io);
    if (rq == spc2wbm_pkg::IMISS_RQ) begin
      return io ? (8'h0f << (4 * lo[2])) : 8'hff;
    end
    if (rq != spc2wbm_pkg::LOAD_RQ && rq != spc2wbm_pkg::STORE_RQ) begin
      return 8'h00;
    end
    case (sz)
      spc2wbm_pkg::SZ_1B:  return 8'h01 << lo;
      spc2wbm_pkg::SZ_2B:  return 8'h03 << (2 * lo[2:1]);
      spc2wbm_pkg::SZ_4B:  return 8'h0f << (4 * lo[2]);
      spc2wbm_pkg::SZ_8B,
      spc2wbm_pkg::SZ_16B: return 8'hff;
      default:             return 8'h00;
    endcase
  endfunction

  // One full request, checked cycle by cycle
  task automatic run_request(input logic [4:0] rq, input logic [2:0] sz,
                             input logic [39:0] addr, input logic [4:0] region,
                             input logic atom, input logic [1:0] thr, input logic nc,
                             input logic [63:0] st_data);
    logic          io;
    int            beats;
    logic [7:0]    sel0;
    logic          we0;
    logic [3:0]    rtype;
    logic          atomic_ret;
    logic [127:0]  exp_data;
    logic [63:0]   bus_addr;
    logic [63:0]   rd;
    int            cnt;
    int            b;
    io         = (region == `SPC2WBM_IO_REGION);
    sel0       = beat0_select(rq, sz, addr[2:0], io);
    we0        = 1'b1;
    beats      = 1;
    rtype      = spc2wbm_pkg::ST_ACK;
    atomic_ret = atom;
    case (rq)
      spc2wbm_pkg::LOAD_RQ: begin
        we0   = 1'b0;
        beats = (sz == spc2wbm_pkg::SZ_16B) ? 2 : 1;
        rtype = spc2wbm_pkg::LOAD_RET;
      end
      spc2wbm_pkg::IMISS_RQ: begin
        we0        = 1'b0;
        beats      = io ? 2 : 4;
        rtype      = spc2wbm_pkg::IFILL_RET;
        atomic_ret = 1'b0;
      end
      default: ;
    endcase
    req_count++;
    exp_data = '0;
    // Request and packet presented together
    @(negedge clk);
    spc_req    = region;
    spc_atom   = atom;
    spc_packet = {1'b1, rq, nc, 3'($urandom), thr, 1'b0, 2'b00, 2'b00, sz, addr, st_data};
    @(negedge clk);
    spc_req  = '0;
    spc_atom = 1'b0;
    compare($sformatf("req%0d stall rise", req_count), 1, spc_stall);
    compare($sformatf("req%0d no early grant", req_count), 0, spc_grant);
    @(negedge clk);
    compare($sformatf("req%0d grant", req_count), region, spc_grant);
    compare($sformatf("req%0d stall fall", req_count), 0, spc_stall);
    spc_packet = '0;
    for (b = 0; b < beats; b++) begin
      @(negedge clk);
      bus_addr = {region, {`SPC2WBM_ADDR_PAD{1'b0}}, beat_address(addr, b)};
      compare($sformatf("req%0d beat%0d strobe", req_count, b), 1, wbm_strobe);
      compare($sformatf("req%0d beat%0d cycle", req_count, b), 1, wbm_cycle);
      compare($sformatf("req%0d beat%0d address", req_count, b), bus_addr, wbm_addr);
      compare($sformatf("req%0d beat%0d we", req_count, b), (b == 0) ? we0 : 1'b0, wbm_we);
      compare($sformatf("req%0d beat%0d sel", req_count, b), (b == 0) ? sel0 : 8'hff, wbm_sel);
      compare($sformatf("req%0d beat%0d data", req_count, b), (b == 0) ? st_data : 64'h0,
              wbm_wdata);
      // First fill packet leaves as beat 2 starts
      if (b == 2) begin
        compare($sformatf("req%0d mid ready", req_count), 1, spc_ready);
        compare($sformatf("req%0d mid packet", req_count),
                build_cpx(rtype, nc, thr, io, 1'b0, exp_data), spc_packetin);
      end else begin
        compare($sformatf("req%0d beat%0d ready", req_count, b), 0, spc_ready);
      end
      cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
      end while (wbm_strobe && cnt < ACK_LIMIT);
      if (wbm_strobe) begin
        timeout_fail($sformatf("request %0d beat %0d got no Wishbone ack", req_count, b));
      end
      // Cycle after the ack
      rd = ~bus_addr;
      case (b)
        0:       exp_data = addr[3] ? {64'h0, rd} : {rd, 64'h0};
        1:       exp_data[63:0] = rd;
        2:       exp_data = {rd, 64'h0};
        default: exp_data[63:0] = rd;
      endcase
      compare($sformatf("req%0d beat%0d cycle after ack", req_count, b), atom, wbm_cycle);
      if (b == beats - 1) begin
        if (beats == 4) begin
          atomic_ret = 1'b1;
        end
        compare($sformatf("req%0d final ready", req_count), 1, spc_ready);
        compare($sformatf("req%0d resume", req_count), 1, spc_resume);
        compare($sformatf("req%0d final packet", req_count),
                build_cpx(rtype, nc, thr, io, atomic_ret, exp_data), spc_packetin);
      end else begin
        compare($sformatf("req%0d beat%0d no resume", req_count, b), 0, spc_resume);
        compare($sformatf("req%0d beat%0d no ready", req_count, b), 0, spc_ready);
      end
    end
    // Back in idle
    @(negedge clk);
    compare($sformatf("req%0d ready drop", req_count), 0, spc_ready);
    compare($sformatf("req%0d resume drop", req_count), 0, spc_resume);
    compare($sformatf("req%0d idle stall", req_count), 0, spc_stall);
  endtask

  initial begin
    logic [4:0]  rq;
    logic [2:0]  sz;
    logic [63:0] rnd;
    logic [63:0] st;
    logic [4:0]  region;
    logic        atom;
    logic [1:0]  thr;
    logic        nc;
    int          n;
    void'($urandom(22727));
    req_count  = 0;
    sizes      = '{spc2wbm_pkg::SZ_1B, spc2wbm_pkg::SZ_2B, spc2wbm_pkg::SZ_4B,
                   spc2wbm_pkg::SZ_8B, spc2wbm_pkg::SZ_16B};
    sys_reset  = 1'b1;
    spc_req    = '0;
    spc_atom   = 1'b0;
    spc_packet = '0;
    // Outputs quiet through the whole reset window
    for (n = 0; n < 16; n++) begin
      @(negedge clk);
      compare("reset core outputs", 160'h0,
              {spc_grant, spc_ready, spc_packetin, spc_stall, spc_resume});
      compare("reset bus outputs", 160'h0,
              {wbm_cycle, wbm_strobe, wbm_we, wbm_addr, wbm_wdata, wbm_sel});
    end
    sys_reset = 1'b0;
    @(negedge clk);
    compare("wakeup ready", 1, spc_ready);
    compare("wakeup resume", 0, spc_resume);
    compare("wakeup packet", build_cpx(spc2wbm_pkg::INT_RET, 1'b0, 2'b00, 1'b0, 1'b0,
                                       {64'h0, `SPC2WBM_WAKEUP_DATA}), spc_packetin);
    // Single wakeup only
    repeat (4) begin
      @(negedge clk);
      compare("ready after wakeup", 0, spc_ready);
    end
    // Directed cases
    run_request(spc2wbm_pkg::LOAD_RQ, spc2wbm_pkg::SZ_1B, 40'h12_3456_7895, 5'b00001,
                1'b0, 2'd1, 1'b0, 64'h0);
    run_request(spc2wbm_pkg::STORE_RQ, spc2wbm_pkg::SZ_4B, 40'h00_0000_1004, 5'b00010,
                1'b1, 2'd2, 1'b1, 64'hdead_beef_0123_4567);
    run_request(UNSUP_RQ, spc2wbm_pkg::SZ_8B, 40'h00_0000_2008, 5'b00100,
                1'b0, 2'd3, 1'b0, 64'h1111_2222_3333_4444);
    run_request(spc2wbm_pkg::LOAD_RQ, spc2wbm_pkg::SZ_16B, 40'h80_0000_0010, 5'b00001,
                1'b1, 2'd0, 1'b1, 64'h0);
    run_request(spc2wbm_pkg::IMISS_RQ, spc2wbm_pkg::SZ_4B, 40'hff_f000_0024,
                `SPC2WBM_IO_REGION, 1'b0, 2'd1, 1'b1, 64'h0);
    run_request(spc2wbm_pkg::IMISS_RQ, spc2wbm_pkg::SZ_8B, 40'h00_4000_0020, 5'b00001,
                1'b0, 2'd2, 1'b0, 64'h0);
    run_request(spc2wbm_pkg::IMISS_RQ, spc2wbm_pkg::SZ_8B, 40'h00_4000_0040, 5'b00010,
                1'b1, 2'd3, 1'b0, 64'h0);
    // Random mix
    for (n = 0; n < RANDOM_REQS; n++) begin
      case ($urandom % 4)
        0:       rq = spc2wbm_pkg::LOAD_RQ;
        1:       rq = spc2wbm_pkg::STORE_RQ;
        2:       rq = spc2wbm_pkg::IMISS_RQ;
        default: rq = UNSUP_RQ;
      endcase
      sz     = sizes[$urandom % 5];
      rnd    = {$urandom, $urandom};
      st     = {$urandom, $urandom};
      region = 5'b00001 << ($urandom % 5);
      atom   = $urandom % 2;
      thr    = $urandom % 4;
      nc     = $urandom % 2;
      run_request(rq, sz, rnd[39:0], region, atom, thr, nc, st);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/spc2wbm_pkg.sv
hw/bridge_req_if.sv
hw/bridge_fsm.sv
hw/beat_counter.sv
hw/pcx_decoder.sv
hw/wb_master.sv
hw/cpx_encoder.sv
hw/spc2wbm_top.sv
tests/wb_slave_model.sv
tests/tb_spc2wbm.sv
